/* source/masku_params.svh */
// Mask unit sizing constants, included by the mask unit package only

`ifndef MASKU_PARAMS_SVH
`define MASKU_PARAMS_SVH

// Number of lanes in the vector processor
`define MASKU_NR_LANES 4

// Lane word width in bits
`define MASKU_ELEN 64

// Vector length and bit count width
`define MASKU_VL_WIDTH 16

// Register file word address width
`define MASKU_ADDR_WIDTH 8

// Instruction id width and scalar result width
`define MASKU_ID_WIDTH 3
`define MASKU_XLEN 64

// Write-back queue depth
`define MASKU_RQ_DEPTH 2

`endif

/* source/masku_pkg.sv */
// Shared types and enums of the mask unit, referenced by scoped name from RTL and testbench

`include "masku_params.svh"

package masku_pkg;

  // Sizes taken from the parameter header
  localparam int unsigned NR_LANES   = `MASKU_NR_LANES;
  localparam int unsigned ELEN       = `MASKU_ELEN;
  localparam int unsigned VL_WIDTH   = `MASKU_VL_WIDTH;
  localparam int unsigned ADDR_WIDTH = `MASKU_ADDR_WIDTH;
  localparam int unsigned ID_WIDTH   = `MASKU_ID_WIDTH;
  localparam int unsigned XLEN       = `MASKU_XLEN;
  localparam int unsigned RQ_DEPTH   = `MASKU_RQ_DEPTH;
  // One beat holds a word from every lane
  localparam int unsigned BEAT_BITS  = NR_LANES * ELEN;

  typedef logic [ELEN-1:0]              lane_word_t;
  typedef lane_word_t [NR_LANES-1:0]    lane_words_t;
  typedef logic [NR_LANES-1:0]          lane_bits_t;
  typedef logic [VL_WIDTH-1:0]          vl_t;
  typedef logic [ADDR_WIDTH-1:0]        vaddr_t;
  typedef logic [ID_WIDTH-1:0]          vid_t;
  typedef logic [XLEN-1:0]              xlen_t;
  // Enough bits to hold a count of BEAT_BITS
  typedef logic [$clog2(BEAT_BITS):0]   beat_cnt_t;

  typedef enum logic {
    MASKU_OP_LOGIC,
    MASKU_OP_CPOP
  } masku_op_e;

  typedef enum logic [1:0] {
    CTRL_IDLE,
    CTRL_ISSUE,
    CTRL_COMMIT
  } ctrl_state_e;

endpackage

/* source/masku_ctrl.sv */
// Mask unit control FSM that accepts one instruction, counts operand beats and sequences commit
`timescale 1ns/1ps

module masku_ctrl (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // Sequencer request
  input  logic                  req_valid_i,
  input  masku_pkg::masku_op_e  req_op_i,
  input  masku_pkg::vl_t        req_vl_i,
  input  logic                  req_vm_i,
  input  masku_pkg::vaddr_t     req_vd_i,
  input  masku_pkg::vid_t       req_id_i,
  output logic                  req_ready_o,
  // Operand beat handshake
  input  logic                  operand_valid_i,
  output logic                  operand_ready_o,
  // Datapath control
  output masku_pkg::vl_t        vl_rem_o,
  output logic                  vm_o,
  input  logic                  rq_full_i,
  input  logic                  rq_empty_i,
  output logic                  rq_push_o,
  output masku_pkg::vaddr_t     push_addr_o,
  output masku_pkg::vid_t       push_id_o,
  output logic                  acc_add_o,
  output logic                  acc_last_o,
  input  logic                  scalar_taken_i,
  // Completion
  output logic                  done_o,
  output masku_pkg::vid_t       done_id_o
);

  masku_pkg::ctrl_state_e state_q, state_d;
  masku_pkg::masku_op_e   op_q;
  logic                   vm_q;
  masku_pkg::vaddr_t      vd_q;
  masku_pkg::vid_t        id_q;
  masku_pkg::vaddr_t      beat_idx_q;
  masku_pkg::vl_t         vl_rem_q;
  logic                   done_q;

  logic req_fire;
  logic beat_fire;
  logic last_beat;
  logic commit_end;

  //////////////////////////////////////////////////
  // Handshakes

  // Only one instruction in flight
  assign req_ready_o = (state_q == masku_pkg::CTRL_IDLE);
  assign req_fire    = req_valid_i && req_ready_o;

  // CPOP beats never wait on the write-back queue
  assign operand_ready_o = (state_q == masku_pkg::CTRL_ISSUE) && operand_valid_i &&
                           ((op_q == masku_pkg::MASKU_OP_CPOP) || !rq_full_i);
  assign beat_fire       = operand_valid_i && operand_ready_o;

  // A remainder of one beat or less (zero included) ends the issue phase
  assign last_beat = (vl_rem_q <= masku_pkg::vl_t'(masku_pkg::BEAT_BITS));

  // Steer the beat to the queue or the accumulator
  assign rq_push_o   = beat_fire && (op_q == masku_pkg::MASKU_OP_LOGIC);
  assign push_addr_o = vd_q + beat_idx_q;
  assign push_id_o   = id_q;
  assign acc_add_o   = beat_fire && (op_q == masku_pkg::MASKU_OP_CPOP);
  assign acc_last_o  = acc_add_o && last_beat;

  // Write-back drained or scalar taken by the dispatcher
  assign commit_end = (state_q == masku_pkg::CTRL_COMMIT) &&
                      ((op_q == masku_pkg::MASKU_OP_LOGIC) ? rq_empty_i : scalar_taken_i);

  assign vl_rem_o  = vl_rem_q;
  assign vm_o      = vm_q;
  assign done_o    = done_q;
  // Id stays latched until the next acceptance
  assign done_id_o = id_q;

  //////////////////////////////////////////////////
  // State machine

  always_comb begin
    state_d = state_q;
    case (state_q)
      masku_pkg::CTRL_IDLE:   if (req_fire) state_d = masku_pkg::CTRL_ISSUE;
      masku_pkg::CTRL_ISSUE:  if (beat_fire && last_beat) state_d = masku_pkg::CTRL_COMMIT;
      masku_pkg::CTRL_COMMIT: if (commit_end) state_d = masku_pkg::CTRL_IDLE;
      default:                state_d = masku_pkg::CTRL_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= masku_pkg::CTRL_IDLE;
      op_q       <= masku_pkg::MASKU_OP_LOGIC;
      vm_q       <= 1'b0;
      vd_q       <= '0;
      id_q       <= '0;
      beat_idx_q <= '0;
      vl_rem_q   <= '0;
      done_q     <= 1'b0;
    end else begin
      state_q <= state_d;
      done_q  <= commit_end;
      // Latch the instruction
      if (req_fire) begin
        op_q       <= req_op_i;
        vm_q       <= req_vm_i;
        vd_q       <= req_vd_i;
        id_q       <= req_id_i;
        beat_idx_q <= '0;
        vl_rem_q   <= req_vl_i;
      end
      // Remainder saturates at zero on the last beat
      if (beat_fire) begin
        beat_idx_q <= beat_idx_q + 1'b1;
        vl_rem_q   <= last_beat ? '0 : vl_rem_q - masku_pkg::vl_t'(masku_pkg::BEAT_BITS);
      end
    end
  end

  //////////////////////////////////////////////////
  // Assertions

  // An idle unit has drained its write-back queue
  a_ready_drained : assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_ready_o |-> rq_empty_i);

endmodule

/* source/masku_alu.sv */
// Mask unit combinational datapath, vl bit enable, tail merge and masked popcount of one beat
`timescale 1ns/1ps

module masku_alu (
  input  masku_pkg::vl_t          vl_rem_i,
  input  logic                    vm_i,
  input  masku_pkg::lane_words_t  operand_a_i,
  input  masku_pkg::lane_words_t  operand_b_i,
  input  masku_pkg::lane_words_t  operand_m_i,
  output masku_pkg::lane_words_t  merged_o,
  output masku_pkg::beat_cnt_t    beat_cnt_o
);

  // Flat lane-major views, lane 0 in the low bits
  logic [masku_pkg::BEAT_BITS-1:0] a_flat;
  logic [masku_pkg::BEAT_BITS-1:0] b_flat;
  logic [masku_pkg::BEAT_BITS-1:0] m_flat;

  // Bits of this beat that are below vl
  logic [masku_pkg::BEAT_BITS-1:0] bit_en;
  // Enable further filtered by the mask operand
  logic [masku_pkg::BEAT_BITS-1:0] cnt_en;
  logic [masku_pkg::BEAT_BITS-1:0] merged_flat;
  logic [masku_pkg::BEAT_BITS-1:0] cnt_bits;

  assign a_flat = operand_a_i;
  assign b_flat = operand_b_i;
  assign m_flat = operand_m_i;

  //////////////////////////////////////////////////
  // Bit enable

  // Every bit set once vl_rem reaches a full beat
  always_comb begin
    for (int unsigned i = 0; i < masku_pkg::BEAT_BITS; i++) begin
      bit_en[i] = (masku_pkg::vl_t'(i) < vl_rem_i);
    end
  end

  // Unmasked when vm is set
  assign cnt_en = vm_i ? bit_en : (bit_en & m_flat);

  //////////////////////////////////////////////////
  // Tail merge

  // Body from a, tail keeps the old destination b
  assign merged_flat = (a_flat & bit_en) | (b_flat & ~bit_en);
  assign merged_o    = merged_flat;

  //////////////////////////////////////////////////
  // Population count

  assign cnt_bits = b_flat & cnt_en;

  always_comb begin
    masku_pkg::beat_cnt_t sum;
    sum = '0;
    // Plain adder chain over the beat
    for (int unsigned i = 0; i < masku_pkg::BEAT_BITS; i++) begin
      sum = sum + masku_pkg::beat_cnt_t'(cnt_bits[i]);
    end
    beat_cnt_o = sum;
  end

endmodule

/* source/masku_result_queue.sv */
// Per-lane write-back queue, lanes are granted independently and the head pops once all are done
`timescale 1ns/1ps

module masku_result_queue (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  // Push side from the control
  input  logic                    push_i,
  input  masku_pkg::lane_words_t  push_data_i,
  input  masku_pkg::vaddr_t       push_addr_i,
  input  masku_pkg::vid_t         push_id_i,
  output logic                    full_o,
  output logic                    empty_o,
  // Write-back to the lanes
  output masku_pkg::lane_bits_t   result_req_o,
  output masku_pkg::vaddr_t       result_addr_o,
  output masku_pkg::vid_t         result_id_o,
  output masku_pkg::lane_words_t  result_wdata_o,
  input  masku_pkg::lane_bits_t   result_gnt_i
);

  localparam int unsigned DEPTH = masku_pkg::RQ_DEPTH;
  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  typedef logic [PTR_W-1:0] ptr_t;

  // Entry payload
  masku_pkg::lane_words_t data_q [DEPTH];
  masku_pkg::vaddr_t      addr_q [DEPTH];
  masku_pkg::vid_t        id_q   [DEPTH];
  // Lanes still waiting for a grant, per entry
  masku_pkg::lane_bits_t  pend_q [DEPTH];

  ptr_t             rd_ptr_q, wr_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             pop;

  function automatic ptr_t ptr_inc(ptr_t ptr);
    ptr_inc = (ptr == ptr_t'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign full_o  = (count_q == CNT_W'(DEPTH));
  assign empty_o = (count_q == '0);

  // Head entry, driven from registers only
  assign result_req_o   = empty_o ? '0 : pend_q[rd_ptr_q];
  assign result_addr_o  = addr_q[rd_ptr_q];
  assign result_id_o    = id_q[rd_ptr_q];
  assign result_wdata_o = data_q[rd_ptr_q];

  // Last grant cleared the vector on the previous edge
  assign pop = !empty_o && (pend_q[rd_ptr_q] == '0);

  //////////////////////////////////////////////////
  // Pointers, count and pending lanes

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
      for (int unsigned e = 0; e < DEPTH; e++) begin
        pend_q[e] <= '0;
      end
    end else begin
      // Granted lanes drop their request
      for (int unsigned l = 0; l < masku_pkg::NR_LANES; l++) begin
        if (result_req_o[l] && result_gnt_i[l]) begin
          pend_q[rd_ptr_q][l] <= 1'b0;
        end
      end
      if (push_i) begin
        pend_q[wr_ptr_q] <= '1;
        wr_ptr_q         <= ptr_inc(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      case ({push_i, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // Payload storage
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      data_q[wr_ptr_q] <= push_data_i;
      addr_q[wr_ptr_q] <= push_addr_i;
      id_q[wr_ptr_q]   <= push_id_i;
    end
  end

  // Control must hold beats back while the queue is full
  a_no_push_full : assert property (@(posedge clk_i) disable iff (!rst_ni)
    push_i |-> !full_o);

endmodule

/* source/masku_scalar_acc.sv */
// Popcount accumulator with the scalar result register handed to the dispatcher
`timescale 1ns/1ps

module masku_scalar_acc (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  add_i,
  input  logic                  last_i,
  input  masku_pkg::beat_cnt_t  beat_cnt_i,
  // Dispatcher handshake
  input  logic                  scalar_ready_i,
  output masku_pkg::xlen_t      scalar_o,
  output logic                  scalar_valid_o,
  output logic                  scalar_taken_o
);

  masku_pkg::xlen_t acc_q;
  logic             valid_q;

  assign scalar_o       = acc_q;
  assign scalar_valid_o = valid_q;
  assign scalar_taken_o = valid_q && scalar_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      acc_q   <= '0;
      valid_q <= 1'b0;
    end else if (scalar_taken_o) begin
      // Clear for the next CPOP
      acc_q   <= '0;
      valid_q <= 1'b0;
    end else if (add_i) begin
      acc_q   <= acc_q + masku_pkg::xlen_t'(beat_cnt_i);
      valid_q <= last_i;
    end
  end

  a_no_add_valid : assert property (@(posedge clk_i) disable iff (!rst_ni)
    add_i |-> !scalar_valid_o);

  // Result held stable under back-pressure
  a_hold_stable : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (scalar_valid_o && !scalar_ready_i) |=> (scalar_valid_o && $stable(scalar_o)));

endmodule

/* source/masku_top.sv */
// Mask unit top level, ties the control FSM to the ALU, write-back queue and scalar accumulator
`timescale 1ns/1ps

module masku_top (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  // Sequencer
  input  logic                    req_valid_i,
  input  masku_pkg::masku_op_e    req_op_i,
  input  masku_pkg::vl_t          req_vl_i,
  input  logic                    req_vm_i,
  input  masku_pkg::vaddr_t       req_vd_i,
  input  masku_pkg::vid_t         req_id_i,
  output logic                    req_ready_o,
  // Lane operands
  input  masku_pkg::lane_words_t  operand_a_i,
  input  masku_pkg::lane_words_t  operand_b_i,
  input  masku_pkg::lane_words_t  operand_m_i,
  input  logic                    operand_valid_i,
  output logic                    operand_ready_o,
  // Write-back
  output masku_pkg::lane_bits_t   result_req_o,
  output masku_pkg::vaddr_t       result_addr_o,
  output masku_pkg::vid_t         result_id_o,
  output masku_pkg::lane_words_t  result_wdata_o,
  input  masku_pkg::lane_bits_t   result_gnt_i,
  // Dispatcher
  output masku_pkg::xlen_t        scalar_o,
  output logic                    scalar_valid_o,
  input  logic                    scalar_ready_i,
  // Completion
  output logic                    done_o,
  output masku_pkg::vid_t         done_id_o
);

  masku_pkg::vl_t         vl_rem;
  logic                   vm;
  logic                   rq_push, rq_full, rq_empty;
  masku_pkg::vaddr_t      push_addr;
  masku_pkg::vid_t        push_id;
  logic                   acc_add, acc_last, scalar_taken;
  masku_pkg::lane_words_t merged;
  masku_pkg::beat_cnt_t   beat_cnt;

  masku_ctrl i_ctrl (
    .clk_i, .rst_ni,
    .req_valid_i, .req_op_i, .req_vl_i, .req_vm_i, .req_vd_i, .req_id_i, .req_ready_o,
    .operand_valid_i, .operand_ready_o,
    .vl_rem_o       (vl_rem),
    .vm_o           (vm),
    .rq_full_i      (rq_full),
    .rq_empty_i     (rq_empty),
    .rq_push_o      (rq_push),
    .push_addr_o    (push_addr),
    .push_id_o      (push_id),
    .acc_add_o      (acc_add),
    .acc_last_o     (acc_last),
    .scalar_taken_i (scalar_taken),
    .done_o, .done_id_o
  );

  masku_alu i_alu (
    .vl_rem_i   (vl_rem),
    .vm_i       (vm),
    .operand_a_i, .operand_b_i, .operand_m_i,
    .merged_o   (merged),
    .beat_cnt_o (beat_cnt)
  );

  masku_result_queue i_result_queue (
    .clk_i, .rst_ni,
    .push_i      (rq_push),
    .push_data_i (merged),
    .push_addr_i (push_addr),
    .push_id_i   (push_id),
    .full_o      (rq_full),
    .empty_o     (rq_empty),
    .result_req_o, .result_addr_o, .result_id_o, .result_wdata_o, .result_gnt_i
  );

  masku_scalar_acc i_scalar_acc (
    .clk_i, .rst_ni,
    .add_i          (acc_add),
    .last_i         (acc_last),
    .beat_cnt_i     (beat_cnt),
    .scalar_ready_i, .scalar_o, .scalar_valid_o,
    .scalar_taken_o (scalar_taken)
  );

endmodule

/* verif/masku_tb_clk.sv */
// Clock and reset source for the mask unit testbench, 100 ns period and reset held 10 cycles
`timescale 1ns/1ps

module masku_tb_clk (
  output logic clk_o,
  output logic rst_no
);

  // Free running clock, 50 ns per half period
  initial begin
    clk_o = 1'b0;
    forever #50 clk_o = ~clk_o;
  end

  // Reset released after the tenth rising edge
  initial begin
    rst_no = 1'b0;
    repeat (10) @(posedge clk_o);
    rst_no <= 1'b1;
  end

endmodule

/* verif/masku_tb.sv */
// Directed testbench for the mask unit top level that is compiled with vlog.f and run as masku_tb
`timescale 1ns/1ps

module masku_tb;

  localparam int unsigned TIMEOUT = 200;

  logic                   clk;
  logic                   rst_n;
  // Stimulus
  logic                   req_valid;
  masku_pkg::masku_op_e   req_op;
  masku_pkg::vl_t         req_vl;
  logic                   req_vm;
  masku_pkg::vaddr_t      req_vd;
  masku_pkg::vid_t        req_id;
  masku_pkg::lane_words_t op_a;
  masku_pkg::lane_words_t op_b;
  masku_pkg::lane_words_t op_m;
  logic                   op_valid;
  masku_pkg::lane_bits_t  gnt;
  logic                   scalar_ready;
  // Responses
  logic                   req_ready;
  logic                   op_ready;
  logic                   scalar_valid;
  logic                   done;
  masku_pkg::lane_bits_t  res_req;
  masku_pkg::vaddr_t      res_addr;
  masku_pkg::vid_t        res_id;
  masku_pkg::vid_t        done_id;
  masku_pkg::lane_words_t res_wdata;
  masku_pkg::xlen_t       scalar;

  // Operand beats of the running test
  masku_pkg::lane_words_t beat_a[$];
  masku_pkg::lane_words_t beat_b[$];
  masku_pkg::lane_words_t beat_m[$];
  // Done ids in order of arrival
  masku_pkg::vid_t        done_ids[$];
  int unsigned            exp_done;
  int unsigned            err_cnt;
  int unsigned            tests_run;
  int unsigned            tests_failed;

  masku_tb_clk i_clk (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  masku_top dut_i (
    .clk_i (clk), .rst_ni (rst_n),
    .req_valid_i (req_valid), .req_op_i (req_op), .req_vl_i (req_vl), .req_vm_i (req_vm),
    .req_vd_i (req_vd), .req_id_i (req_id), .req_ready_o (req_ready),
    .operand_a_i (op_a), .operand_b_i (op_b), .operand_m_i (op_m),
    .operand_valid_i (op_valid), .operand_ready_o (op_ready),
    .result_req_o (res_req), .result_addr_o (res_addr), .result_id_o (res_id),
    .result_wdata_o (res_wdata), .result_gnt_i (gnt),
    .scalar_o (scalar), .scalar_valid_o (scalar_valid), .scalar_ready_i (scalar_ready),
    .done_o (done), .done_id_o (done_id)
  );

  // Pulse held in the previous cycle is seen here
  always @(posedge clk) begin
    if (rst_n && done) begin
      done_ids.push_back(done_id);
    end
  end

  //////////////////////////////////////////////////
  // Reporting and compare

  task automatic report_fail(input string what);
    $display("At %0t: %s", $time, what);
    err_cnt++;
  endtask

  task automatic report_timeout(input string what);
    $display("At %0t: gave up waiting for %s after %0d cycles", $time, what, TIMEOUT);
    err_cnt++;
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("[ERROR] %0t %s got %b expected %b", $time, name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_word(input string name, input masku_pkg::lane_word_t got,
                            input masku_pkg::lane_word_t exp);
    if (got !== exp) begin
      $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_addr(input string name, input masku_pkg::vaddr_t got,
                            input masku_pkg::vaddr_t exp);
    if (got !== exp) begin
      $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_id(input string name, input masku_pkg::vid_t got,
                          input masku_pkg::vid_t exp);
    if (got !== exp) begin
      $display("[ERROR] %0t %s got %0d expected %0d", $time, name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_scalar(input string name, input masku_pkg::xlen_t got,
                              input masku_pkg::xlen_t exp);
    if (got !== exp) begin
      $display("[ERROR] %0t %s got %0d expected %0d", $time, name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic end_test(input string name, input int unsigned errs_before);
    tests_run++;
    if (err_cnt == errs_before) begin
      $display("%s: ok", name);
    end else begin
      tests_failed++;
      $display("%s: %0d error(s)", name, err_cnt - errs_before);
    end
  endtask

  //////////////////////////////////////////////////
  // Reference model

  function automatic int unsigned num_beats(input masku_pkg::vl_t vl);
    // Zero length still moves one beat
    return (vl == 0) ? 1 : (vl + masku_pkg::BEAT_BITS - 1) / masku_pkg::BEAT_BITS;
  endfunction

  function automatic masku_pkg::lane_words_t rand_beat();
    masku_pkg::lane_words_t w;
    for (int unsigned l = 0; l < masku_pkg::NR_LANES; l++) begin
      w[l] = {$urandom, $urandom};
    end
    return w;
  endfunction

  // Body bits from a and tail bits from b over the lane-major flat index
  function automatic masku_pkg::lane_words_t merge_model(input masku_pkg::lane_words_t a,
      input masku_pkg::lane_words_t b, input int unsigned k, input masku_pkg::vl_t vl);
    masku_pkg::lane_words_t r;
    int unsigned            lane;
    int unsigned            pos;
    for (int unsigned i = 0; i < masku_pkg::BEAT_BITS; i++) begin
      lane = i / masku_pkg::ELEN;
      pos  = i % masku_pkg::ELEN;
      r[lane][pos] = (k * masku_pkg::BEAT_BITS + i < vl) ? a[lane][pos] : b[lane][pos];
    end
    return r;
  endfunction

  // Set bits of b below vl and filtered by m unless vm
  function automatic masku_pkg::xlen_t count_model(input int unsigned nbeats,
      input masku_pkg::vl_t vl, input logic vm);
    masku_pkg::xlen_t cnt;
    int unsigned      lane;
    int unsigned      pos;
    cnt = '0;
    for (int unsigned k = 0; k < nbeats; k++) begin
      for (int unsigned i = 0; i < masku_pkg::BEAT_BITS; i++) begin
        lane = i / masku_pkg::ELEN;
        pos  = i % masku_pkg::ELEN;
        if ((k * masku_pkg::BEAT_BITS + i < vl) && beat_b[k][lane][pos] &&
            (vm || beat_m[k][lane][pos])) begin
          cnt++;
        end
      end
    end
    return cnt;
  endfunction

  task automatic fill_beats(input int unsigned nbeats);
    beat_a.delete();
    beat_b.delete();
    beat_m.delete();
    for (int unsigned k = 0; k < nbeats; k++) begin
      beat_a.push_back(rand_beat());
      beat_b.push_back(rand_beat());
      beat_m.push_back(rand_beat());
    end
  endtask

  //////////////////////////////////////////////////
  // Stimulus

  // Holds the request until ready, reports stall cycles and done at acceptance
  task automatic send_request(input masku_pkg::masku_op_e op, input masku_pkg::vl_t vl,
      input logic vm, input masku_pkg::vaddr_t vd, input masku_pkg::vid_t id,
      output int unsigned stalls, output logic done_seen);
    int unsigned n;
    @(posedge clk);
    req_valid <= 1'b1;
    req_op    <= op;
    req_vl    <= vl;
    req_vm    <= vm;
    req_vd    <= vd;
    req_id    <= id;
    n = 0;
    @(negedge clk);
    while (!req_ready && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    stalls    = n;
    done_seen = done;
    if (!req_ready) begin
      report_timeout("request ready");
    end
    @(posedge clk);
    req_valid <= 1'b0;
  endtask

  task automatic send_beats(input int unsigned nbeats, output int unsigned stalls);
    int unsigned n;
    stalls = 0;
    for (int unsigned k = 0; k < nbeats; k++) begin
      @(posedge clk);
      op_valid <= 1'b1;
      op_a     <= beat_a[k];
      op_b     <= beat_b[k];
      op_m     <= beat_m[k];
      n = 0;
      @(negedge clk);
      while (!op_ready && n < TIMEOUT) begin
        stalls++;
        @(negedge clk);
        n++;
      end
      if (!op_ready) begin
        report_timeout("operand ready");
      end
    end
    @(posedge clk);
    op_valid <= 1'b0;
  endtask

  // Checks each head entry, then grants the lanes after random delays
  task automatic collect_results(input int unsigned nbeats, input masku_pkg::vaddr_t vd,
      input masku_pkg::vid_t id, input masku_pkg::vl_t vl, input int unsigned max_dly);
    masku_pkg::lane_words_t exp;
    masku_pkg::lane_bits_t  left;
    masku_pkg::lane_bits_t  nxt;
    int unsigned            dly [masku_pkg::NR_LANES];
    int unsigned            n;
    for (int unsigned k = 0; k < nbeats; k++) begin
      n = 0;
      @(negedge clk);
      while (res_req == '0 && n < TIMEOUT) begin
        @(negedge clk);
        n++;
      end
      if (n >= TIMEOUT) begin
        report_timeout("write-back request");
      end else begin
        if (res_req !== '1) begin
          report_fail("new write-back entry does not request on every lane");
        end
        check_addr("result_addr_o", res_addr, vd + masku_pkg::vaddr_t'(k));
        check_id("result_id_o", res_id, id);
        exp = merge_model(beat_a[k], beat_b[k], k, vl);
        for (int unsigned l = 0; l < masku_pkg::NR_LANES; l++) begin
          check_word($sformatf("result_wdata_o[%0d]", l), res_wdata[l], exp[l]);
          dly[l] = $urandom_range(max_dly, 0);
        end
        left = '1;
        while (left != '0) begin
          @(posedge clk);
          nxt = '0;
          for (int unsigned l = 0; l < masku_pkg::NR_LANES; l++) begin
            if (left[l] && dly[l] == 0) begin
              nxt[l]  = 1'b1;
              left[l] = 1'b0;
            end else if (left[l]) begin
              dly[l]--;
            end
          end
          gnt <= nxt;
        end
        @(posedge clk);
        gnt <= '0;
      end
    end
  endtask

  task automatic wait_done(input int unsigned idx, input masku_pkg::vid_t id);
    int unsigned n;
    n = 0;
    @(negedge clk);
    while (done_ids.size() <= idx && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (done_ids.size() <= idx) begin
      report_timeout("done pulse");
    end else begin
      check_id("done_id_o", done_ids[idx], id);
    end
  endtask

  //////////////////////////////////////////////////
  // Tests

  task automatic check_reset_state();
    int unsigned errs;
    errs = err_cnt;
    check_bit("req_ready_o", req_ready, 1'b1);
    check_bit("operand_ready_o", op_ready, 1'b0);
    check_bit("scalar_valid_o", scalar_valid, 1'b0);
    check_bit("done_o", done, 1'b0);
    for (int unsigned l = 0; l < masku_pkg::NR_LANES; l++) begin
      check_bit($sformatf("result_req_o[%0d]", l), res_req[l], 1'b0);
    end
    end_test("reset state", errs);
  endtask

  task automatic run_logic(input string name, input masku_pkg::vl_t vl,
      input masku_pkg::vaddr_t vd, input masku_pkg::vid_t id, input int unsigned max_dly,
      input logic expect_stall);
    int unsigned errs;
    int unsigned nb;
    int unsigned idx;
    int unsigned req_stalls;
    int unsigned beat_stalls;
    logic        done_seen;
    errs = err_cnt;
    nb   = num_beats(vl);
    idx  = exp_done;
    exp_done++;
    fill_beats(nb);
    send_request(masku_pkg::MASKU_OP_LOGIC, vl, 1'b0, vd, id, req_stalls, done_seen);
    fork
      send_beats(nb, beat_stalls);
      collect_results(nb, vd, id, vl, max_dly);
    join
    if (expect_stall && beat_stalls == 0) begin
      report_fail("operand_ready_o was never held low by a full queue");
    end
    wait_done(idx, id);
    end_test(name, errs);
  endtask

  task automatic run_cpop(input string name, input masku_pkg::vl_t vl, input logic vm,
      input masku_pkg::vid_t id);
    int unsigned      errs;
    int unsigned      nb;
    int unsigned      idx;
    int unsigned      n;
    int unsigned      hold;
    int unsigned      req_stalls;
    int unsigned      beat_stalls;
    logic             done_seen;
    masku_pkg::xlen_t exp;
    errs = err_cnt;
    nb   = num_beats(vl);
    idx  = exp_done;
    exp_done++;
    fill_beats(nb);
    exp = count_model(nb, vl, vm);
    send_request(masku_pkg::MASKU_OP_CPOP, vl, vm, '0, id, req_stalls, done_seen);
    send_beats(nb, beat_stalls);
    n = 0;
    @(negedge clk);
    while (!scalar_valid && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (!scalar_valid) begin
      report_timeout("scalar valid");
    end else begin
      // Dispatcher stalls before taking the result
      hold = $urandom_range(6, 1);
      for (int unsigned h = 0; h < hold; h++) begin
        check_bit("scalar_valid_o", scalar_valid, 1'b1);
        check_scalar("scalar_o", scalar, exp);
        @(negedge clk);
      end
      check_scalar("scalar_o", scalar, exp);
      @(posedge clk);
      scalar_ready <= 1'b1;
      @(posedge clk);
      scalar_ready <= 1'b0;
      @(negedge clk);
      check_bit("scalar_valid_o", scalar_valid, 1'b0);
    end
    wait_done(idx, id);
    end_test(name, errs);
  endtask

  // Second request waits while the first one runs
  task automatic run_back_to_back();
    int unsigned errs;
    int unsigned idx1;
    int unsigned idx2;
    int unsigned req_stalls;
    int unsigned beat_stalls;
    logic        done_seen;
    errs = err_cnt;
    idx1 = exp_done;
    idx2 = exp_done + 1;
    exp_done += 2;
    fill_beats(1);
    send_request(masku_pkg::MASKU_OP_LOGIC, 16'd256, 1'b0, 8'h60, 3'd6, req_stalls, done_seen);
    fork
      send_request(masku_pkg::MASKU_OP_LOGIC, 16'd256, 1'b0, 8'h70, 3'd7, req_stalls,
                   done_seen);
      begin
        send_beats(1, beat_stalls);
        collect_results(1, 8'h60, 3'd6, 16'd256, 2);
      end
    join
    if (req_stalls == 0) begin
      report_fail("second request was accepted while the unit was busy");
    end
    check_bit("done_o", done_seen, 1'b1);
    wait_done(idx1, 3'd6);
    send_beats(1, beat_stalls);
    collect_results(1, 8'h70, 3'd7, 16'd256, 2);
    wait_done(idx2, 3'd7);
    end_test("busy unit holds second request", errs);
  endtask

  //////////////////////////////////////////////////
  // Main sequence

  initial begin
    int unsigned n;
    // Seed the generator once
    void'($urandom(73));
    req_valid    = 1'b0;
    req_op       = masku_pkg::MASKU_OP_LOGIC;
    req_vl       = '0;
    req_vm       = 1'b0;
    req_vd       = '0;
    req_id       = '0;
    op_a         = '0;
    op_b         = '0;
    op_m         = '0;
    op_valid     = 1'b0;
    gnt          = '0;
    scalar_ready = 1'b0;
    exp_done     = 0;
    err_cnt      = 0;
    tests_run    = 0;
    tests_failed = 0;
    n = 0;
    @(negedge clk);
    while (!rst_n && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (!rst_n) begin
      report_timeout("reset release");
    end
    check_reset_state();
    run_logic("logic vl 256", 16'd256, 8'h10, 3'd1, 0, 1'b0);
    run_logic("logic vl 100 tail merge", 16'd100, 8'h20, 3'd2, 0, 1'b0);
    run_logic("logic vl 600 back-pressure", 16'd600, 8'h30, 3'd3, 4, 1'b1);
    run_cpop("cpop vl 300 vm set", 16'd300, 1'b1, 3'd4);
    run_cpop("cpop vl 300 vm clear", 16'd300, 1'b0, 3'd5);
    run_back_to_back();
    if (done_ids.size() != exp_done) begin
      report_fail("number of done pulses does not match the number of instructions");
    end
    $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, err_cnt);
    if (err_cnt == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

/* vlog.f */
+incdir+source
source/masku_pkg.sv
source/masku_ctrl.sv
source/masku_alu.sv
source/masku_result_queue.sv
source/masku_scalar_acc.sv
source/masku_top.sv
verif/masku_tb_clk.sv
verif/masku_tb.sv

/* Bender.yml */
package:
  name: masku

sources:
  - include_dirs:
      - source
    files:
      - source/masku_pkg.sv
      - source/masku_ctrl.sv
      - source/masku_alu.sv
      - source/masku_result_queue.sv
      - source/masku_scalar_acc.sv
      - source/masku_top.sv
  - target: test
    files:
      - verif/masku_tb_clk.sv
      - verif/masku_tb.sv
